// File: bench/tb_msx_slots.sv
`timescale 1ns/1ps

module tb_msx_slots import msx_pkg::*; ();

    localparam int ADDR_W      = 27;
    localparam int N_RAND      = 16;                     // Iterations per random phase
    localparam int TEST_CYCLES = 8 + 14 + 7 * N_RAND + 40;  // Sequence length plus slack

    logic               clk;
    logic               rst;
    logic [15:0]        addr;
    logic [7:0]         cpu_din;
    logic               rd;
    logic               wr;
    logic [7:0]         data;
    logic [1:0]         active_slot;
    block_t [3:0]       slot_layout;
    lookup_ram_t [15:0] ram_table;
    lookup_sram_t [3:0] sram_table;
    logic [ADDR_W-1:0]  ram_addr;
    logic [7:0]         ram_din;
    logic               ram_rnw;
    logic               sdram_ce;
    logic [7:0]         ram_dout;
    logic               dev_cs;
    logic [3:0]         dev_num;
    logic [7:0]         dev_din;

    logic [7:0]  mem_model [int];     // Sparse SDRAM contents
    int          mem_writes = 0;      // Bumped on every store, refreshes ram_dout
    logic [7:0]  bank_model [2][4];   // Expected ASCII8 banks per cart
    logic [31:0] rng_state;

    msx_slot_top #(.ADDR_W(ADDR_W)) dut_i (.*);

    function automatic logic [31:0] next_rand();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    // Background pattern of bytes never written, hashed over all address bits
    function automatic logic [7:0] fill_byte(input logic [ADDR_W-1:0] a);
        logic [31:0] h;
        h = 32'(a) * 32'h9e3779b1;
        return h[31:24] ^ h[15:8];
    endfunction

    function automatic logic [7:0] read_byte(input logic [ADDR_W-1:0] a);
        if (mem_model.exists(int'(a))) begin
            return mem_model[int'(a)];
        end
        return fill_byte(a);
    endfunction

    // Base + page * 16 KB + CPU address, wrapped to the entry size
    function automatic logic [ADDR_W-1:0] linear_addr(input lookup_ram_t e,
                                                      input logic [1:0] page,
                                                      input logic [15:0] a);
        longint span;
        span = longint'(e.size) * 16384;
        return ADDR_W'(longint'(e.addr) + (longint'(page) * 16384 + longint'(a)) % span);
    endfunction

    // ASCII8 window, ROM entry 4 and SRAM entry 1
    function automatic logic [ADDR_W-1:0] ascii8_addr(input logic cart, input logic [15:0] a);
        logic [7:0] bank;
        longint     rom_span;
        bank     = bank_model[cart][(a - 16'h4000) / 16'h2000];
        rom_span = longint'(ram_table[4].size) * 16384;
        if (a >= 16'h8000 && bank[7]) begin
            return ADDR_W'(longint'(sram_table[1].addr) + a % sram_table[1].size);
        end
        return ADDR_W'(longint'(ram_table[4].addr)
                       + (longint'(bank) * 8192 + longint'(a % 16'h2000)) % rom_span);
    endfunction

    function automatic block_t mem_block(input mapper_e kind, input logic [3:0] ref_ram,
                                         input logic [1:0] page, input logic cart);
        block_t b;
        b = '0;
        b.kind                   = kind;
        b.payload.mem.ref_ram    = ref_ram;
        b.payload.mem.ref_sram   = 2'd1;     // Only SRAM entry in use
        b.payload.mem.offset_ram = page;
        b.payload.mem.cart_num   = cart;
        return b;
    endfunction

    function automatic block_t dev_block(input mapper_e kind, input logic [3:0] num);
        block_t b;
        b = '0;
        b.kind                   = kind;
        b.payload.dev.device_num = num;
        return b;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0d ns: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check(input logic ok, input string msg);
        assert (ok) else report_mismatch(msg);
    endtask

    // One CPU strobe cycle, sampled at the falling edge
    task automatic cpu_cycle(input logic [1:0] slot, input logic [15:0] a,
                             input logic do_rd, input logic do_wr, input logic [7:0] din);
        @(posedge clk);
        active_slot <= slot;
        addr        <= a;
        rd          <= do_rd;
        wr          <= do_wr;
        cpu_din     <= din;
        dev_din     <= 8'(next_rand());
        @(negedge clk);
    endtask

    task automatic set_layout(input int slot, input block_t blk);
        @(posedge clk);
        rd                <= 1'b0;       // Idle cycle while the layout changes
        wr                <= 1'b0;
        slot_layout[slot] <= blk;
        @(negedge clk);
    endtask

    task automatic check_mem(input logic [ADDR_W-1:0] exp, input logic exp_rnw, input string what);
        check(sdram_ce && !dev_cs, {what, ": no memory request"});
        check(ram_rnw == exp_rnw, $sformatf("%s: ram_rnw %b, expected %b", what, ram_rnw, exp_rnw));
        check(ram_addr == exp, $sformatf("%s: ram_addr %h, expected %h", what, ram_addr, exp));
        if (rd) begin
            check(data == read_byte(exp),
                  $sformatf("%s: data %h, expected %h", what, data, read_byte(exp)));
        end
    endtask

    task automatic ascii8_read(input logic cart, input logic [15:0] a);
        cpu_cycle(2'd2, a, 1'b1, 1'b0, 8'h00);
        check_mem(ascii8_addr(cart, a), 1'b1, $sformatf("ASCII8 read %h", a));
    endtask

    task automatic ascii8_bank_write(input logic cart, input logic [1:0] idx, input logic [7:0] val);
        logic [15:0] a;
        a = 16'h6000 | {3'b000, idx, 11'h000} | 16'(next_rand() & 32'h7FF);
        cpu_cycle(2'd2, a, 1'b0, 1'b1, val);
        check(!sdram_ce && !dev_cs, $sformatf("bank register write %h made a request", a));
        bank_model[cart][idx] = val;         // Live from the next cycle on
    endtask

    // Byte through the ASCII8 SRAM window, then read back
    task automatic sram_write_read(input logic [15:0] a, input logic [ADDR_W-1:0] exp);
        logic [7:0] v;
        v = 8'(next_rand());
        cpu_cycle(2'd2, a, 1'b0, 1'b1, v);
        check_mem(exp, 1'b0, $sformatf("ASCII8 SRAM write %h", a));
        cpu_cycle(2'd2, a, 1'b1, 1'b0, 8'h00);
        check(data == v, $sformatf("ASCII8 SRAM read %h: data %h, expected %h", a, data, v));
    endtask

    // SDRAM model, combinational read
    always @(posedge clk) begin
        if (sdram_ce && !ram_rnw) begin
            mem_model[int'(ram_addr)] = ram_din;
            mem_writes++;
        end
    end

    always @(ram_addr or mem_writes) begin
        ram_dout = read_byte(ram_addr);
    end

    // No strobe means no select, reset included
    always @(negedge clk) begin
        if (!rd && !wr) begin
            check(!sdram_ce && !dev_cs, "select raised with no strobe");
        end
    end

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #((TEST_CYCLES + 100) * 40);
        $display("Timeout: the test sequence did not finish in time");
        $display("Simulation FAILED");
        $fatal(1);
    end

    initial begin
        logic [15:0]       a;
        logic [7:0]        v;
        logic [ADDR_W-1:0] exp;
        logic [7:0]        ram_ref [int];    // Bytes written to the RW RAM entry
        logic [15:0]       addr_q [$];
        rng_state   = 32'hc9f57fad;
        rst         = 1'b1;
        addr        = '0;
        cpu_din     = '0;
        rd          = 1'b0;
        wr          = 1'b0;
        active_slot = '0;
        ram_dout    = '0;
        dev_din     = '0;
        ram_table   = '0;
        sram_table  = '0;
        ram_table[1]  = '{addr: 27'h0100000, size: 16'd4,  ro: 1'b0};  // 64 KB ROM
        ram_table[2]  = '{addr: 27'h0200000, size: 16'd2,  ro: 1'b0};  // 32 KB RAM
        ram_table[3]  = '{addr: 27'h0300000, size: 16'd2,  ro: 1'b1};  // Write protected
        ram_table[4]  = '{addr: 27'h0400000, size: 16'd16, ro: 1'b0};  // 256 KB ASCII8 ROM
        sram_table[1] = '{addr: 27'h0600000, size: 16'h2000};           // 8 KB SRAM
        slot_layout[0] = mem_block(MAP_ROM, 4'd1, 2'd1, 1'b0);
        slot_layout[1] = mem_block(MAP_RAM, 4'd2, 2'd0, 1'b0);
        slot_layout[2] = mem_block(MAP_ASCII8, 4'd4, 2'd0, 1'b0);
        slot_layout[3] = dev_block(MAP_DEVICE, 4'hA);
        for (int c = 0; c < 2; c++) begin
            for (int b = 0; b < 4; b++) begin
                bank_model[c][b] = '0;
            end
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Both carts come up at bank 0, cart 0 writes leave cart 1 alone
        for (int i = 0; i < 4; i++) begin
            ascii8_read(1'b0, 16'h4000 + 16'(i) * 16'h2000 + 16'(next_rand() & 32'h1FFF));
        end
        for (int i = 0; i < 4; i++) begin
            ascii8_bank_write(1'b0, 2'(i), 8'(next_rand()));
        end
        set_layout(2, mem_block(MAP_ASCII8, 4'd4, 2'd0, 1'b1));
        for (int i = 0; i < 4; i++) begin
            ascii8_read(1'b1, 16'h4000 + 16'(i) * 16'h2000 + 16'(next_rand() & 32'h1FFF));
        end
        set_layout(2, mem_block(MAP_ASCII8, 4'd4, 2'd0, 1'b0));

        repeat (N_RAND) begin                 // Linear ROM, page 1
            a = 16'(next_rand());
            cpu_cycle(2'd0, a, 1'b1, 1'b0, 8'h00);
            check_mem(linear_addr(ram_table[1], 2'd1, a), 1'b1, $sformatf("ROM read %h", a));
        end

        repeat (N_RAND) begin                 // RW RAM fill
            a   = 16'(next_rand());
            v   = 8'(next_rand());
            exp = linear_addr(ram_table[2], 2'd0, a);
            cpu_cycle(2'd1, a, 1'b0, 1'b1, v);
            check_mem(exp, 1'b0, $sformatf("RAM write %h", a));
            ram_ref[int'(exp)] = v;           // Aliased addresses keep the last byte
            addr_q.push_back(a);
        end
        foreach (addr_q[i]) begin
            exp = linear_addr(ram_table[2], 2'd0, addr_q[i]);
            cpu_cycle(2'd1, addr_q[i], 1'b1, 1'b0, 8'h00);
            check_mem(exp, 1'b1, $sformatf("RAM read %h", addr_q[i]));
            check(data == ram_ref[int'(exp)],
                  $sformatf("RAM read %h: data %h, expected %h",
                            addr_q[i], data, ram_ref[int'(exp)]));
        end

        set_layout(1, mem_block(MAP_RAM, 4'd3, 2'd0, 1'b0));
        repeat (4) begin                      // Protected entry keeps its contents
            a   = 16'(next_rand());
            exp = linear_addr(ram_table[3], 2'd0, a);
            cpu_cycle(2'd1, a, 1'b0, 1'b1, 8'(next_rand()));
            check_mem(exp, 1'b1, $sformatf("read-only RAM write %h", a));
            cpu_cycle(2'd1, a, 1'b1, 1'b0, 8'h00);
            check(data == fill_byte(exp), $sformatf("read-only RAM at %h was changed", exp));
        end

        repeat (N_RAND) begin                 // ASCII8 bank switching and SRAM
            ascii8_bank_write(1'b0, 2'(next_rand()), 8'(next_rand()));
            a   = 16'h4000 + 16'(next_rand() & 32'h7FFF);
            exp = ascii8_addr(1'b0, a);
            ascii8_read(1'b0, a);
            if (exp >= ADDR_W'(sram_table[1].addr)) begin
                sram_write_read(a, exp);
            end
        end

        // Bank 2 on SRAM so the SRAM path is taken at least once
        ascii8_bank_write(1'b0, 2'd2, 8'h80);
        a = 16'h8000 | 16'(next_rand() & 32'h1FFF);
        ascii8_read(1'b0, a);
        sram_write_read(a, ascii8_addr(1'b0, a));

        repeat (8) begin                      // Device block, number from the union
            v = 8'(next_rand());
            cpu_cycle(2'd3, 16'hC000 | 16'(next_rand() & 32'h3FFF), v[0], ~v[0], v);
            check(dev_cs && !sdram_ce, "device access raised the wrong selects");
            check(dev_num == 4'hA, $sformatf("device number %h, expected a", dev_num));
            check(data == dev_din, $sformatf("device data %h, expected %h", data, dev_din));
        end

        set_layout(3, dev_block(MAP_NONE, 4'h5));
        repeat (8) begin                      // Unmapped slot
            v = 8'(next_rand());
            cpu_cycle(2'd3, 16'(next_rand()), v[0], ~v[0], v);
            check(!dev_cs && !sdram_ce, "unmapped slot raised a select");
            check(data == UNMAPPED_DATA, $sformatf("unmapped data %h, expected ff", data));
        end
        set_layout(3, dev_block(MAP_DEVICE, 4'hA));

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: list.f
src/msx_pkg.sv
src/slot_decode.sv
src/msx_mappers.sv
src/msx_slots.sv
src/msx_slot_top.sv
bench/tb_msx_slots.sv

// File: src/msx_mappers.sv
`timescale 1ns/1ps

module msx_mappers import msx_pkg::*; #(
    parameter int ADDR_W = 27
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [15:0]       addr,          // CPU address
    input  logic [7:0]        cpu_din,       // CPU write data
    input  logic              rd,
    input  logic              wr,
    input  block_t            active_block,
    input  logic [15:0]       ram_blocks,    // ROM/RAM size in 16 KB blocks
    input  logic [15:0]       sram_size,     // SRAM size in bytes
    output logic [ADDR_W-1:0] mem_offset,    // Block relative offset
    output logic              ram_cs,
    output logic              sram_cs,
    output logic              mem_rnw,
    output logic              dev_cs,
    output logic [3:0]        dev_num
);

    block_mem_t        mem_view;
    logic [ADDR_W-1:0] rom_mask;
    logic [ADDR_W-1:0] sram_mask;
    logic [ADDR_W-1:0] linear_offset;
    logic [ADDR_W-1:0] bank_offset;
    logic [7:0]        bank_regs [2][ASCII8_BANKS];  // Per cart bank registers
    logic [1:0]        bank_sel;
    logic [7:0]        bank_val;
    logic              in_window;
    logic              reg_wr;
    logic              sram_hit;

    assign mem_view = active_block.payload.mem;

    // Sizes are powers of two so size minus one is the mask
    assign rom_mask  = (ADDR_W'(ram_blocks) << PAGE_16K_W) - ADDR_W'(1);
    assign sram_mask = ADDR_W'(sram_size) - ADDR_W'(1);

    // Linear ROM/RAM starting at the configured page
    assign linear_offset = ((ADDR_W'(mem_view.offset_ram) << PAGE_16K_W) + ADDR_W'(addr))
                           & rom_mask;

    // ASCII8 window 4000-BFFF in four 8 KB banks
    assign in_window = (addr[15:14] == 2'b01) || (addr[15:14] == 2'b10);
    assign bank_sel  = {addr[15], addr[13]};       // (addr - 4000) / 8 KB
    assign bank_val  = bank_regs[mem_view.cart_num][bank_sel];
    assign sram_hit  = in_window && addr[15] && bank_val[7];  // Upper half only
    assign bank_offset = ((ADDR_W'(bank_val) << BANK_8K_W) + ADDR_W'(addr[12:0]))
                         & rom_mask;

    // Register writes at 6000-7FFF, 2 KB per bank
    assign reg_wr = wr && (active_block.kind == MAP_ASCII8) && (addr[15:13] == 3'b011);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < 2; c++) begin
                for (int b = 0; b < ASCII8_BANKS; b++) begin
                    bank_regs[c][b] <= '0;
                end
            end
        end else if (reg_wr) begin
            bank_regs[mem_view.cart_num][addr[12:11]] <= cpu_din;
        end
    end

    // Request generation per mapper kind
    always_comb begin
        mem_offset = '0;
        ram_cs     = 1'b0;
        sram_cs    = 1'b0;
        mem_rnw    = 1'b1;      // Read unless a write is allowed
        dev_cs     = 1'b0;
        case (active_block.kind)
            MAP_ROM: begin
                ram_cs     = rd;            // Writes dropped
                mem_offset = linear_offset;
            end
            MAP_RAM: begin
                ram_cs     = rd | wr;       // Read-only entries handled later
                mem_rnw    = ~wr;
                mem_offset = linear_offset;
            end
            MAP_ASCII8: begin
                if (sram_hit) begin
                    sram_cs    = rd | wr;
                    mem_rnw    = ~wr;
                    mem_offset = ADDR_W'(addr) & sram_mask;
                end else if (in_window) begin
                    ram_cs     = rd;        // Register writes make no request
                    mem_offset = bank_offset;
                end
            end
            MAP_DEVICE: begin
                dev_cs = rd | wr;
            end
            default: begin
            end
        endcase
    end

    // Device view of the payload
    assign dev_num = (active_block.kind == MAP_DEVICE) ? active_block.payload.dev.device_num
                                                       : 4'd0;

endmodule

// File: src/msx_pkg.sv
package msx_pkg;

    // Address split used by the mappers
    localparam int PAGE_16K_W    = 14;      // Linear ROM/RAM page size, log2
    localparam int BANK_8K_W     = 13;      // ASCII8 bank size, log2
    localparam int ASCII8_BANKS  = 4;       // Bank registers per cart
    localparam int LOOKUP_ADDR_W = 27;      // Base address width in lookup entries

    localparam logic [7:0] UNMAPPED_DATA = 8'hFF;  // Open bus value

    // Mapper kind of a slot block
    typedef enum logic [2:0] {
        MAP_NONE   = 3'd0,
        MAP_ROM    = 3'd1,
        MAP_RAM    = 3'd2,
        MAP_ASCII8 = 3'd3,
        MAP_DEVICE = 3'd4
    } mapper_e;

    // Memory view of the block payload
    typedef struct packed {
        logic [3:0] ref_ram;     // RAM lookup index
        logic [1:0] ref_sram;    // SRAM lookup index
        logic [1:0] offset_ram;  // First 16 KB page inside the RAM entry
        logic       cart_num;    // Bank register set
        logic [3:0] reserved;
    } block_mem_t;

    // Device view of the block payload
    typedef struct packed {
        logic [3:0] device_num;
        logic [8:0] reserved;
    } block_dev_t;

    // Same 13 bits, meaning set by the mapper kind
    typedef union packed {
        block_mem_t mem;
        block_dev_t dev;
    } block_payload_u;

    // One slot layout word
    typedef struct packed {
        mapper_e        kind;
        block_payload_u payload;
    } block_t;

    typedef struct packed {
        logic [LOOKUP_ADDR_W-1:0] addr;  // Base address
        logic [15:0]              size;  // In 16 KB blocks
        logic                     ro;    // Write protect
    } lookup_ram_t;

    typedef struct packed {
        logic [LOOKUP_ADDR_W-1:0] addr;  // Base address
        logic [15:0]              size;  // In bytes
    } lookup_sram_t;

endpackage

// File: src/msx_slot_top.sv
`timescale 1ns/1ps

module msx_slot_top import msx_pkg::*; #(
    parameter int ADDR_W = 27
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [15:0]        addr,          // CPU address
    input  logic [7:0]         cpu_din,
    input  logic               rd,
    input  logic               wr,
    output logic [7:0]         data,          // CPU read data
    input  logic [1:0]         active_slot,
    input  block_t [3:0]       slot_layout,
    input  lookup_ram_t [15:0] ram_table,
    input  lookup_sram_t [3:0] sram_table,
    output logic [ADDR_W-1:0]  ram_addr,      // SDRAM side
    output logic [7:0]         ram_din,
    output logic               ram_rnw,
    output logic               sdram_ce,
    input  logic [7:0]         ram_dout,
    output logic               dev_cs,        // Device side
    output logic [3:0]         dev_num,
    input  logic [7:0]         dev_din
);

    block_t            active_block;
    lookup_ram_t       ram_entry;
    lookup_sram_t      sram_entry;
    logic [ADDR_W-1:0] mem_offset;
    logic              ram_cs;
    logic              sram_cs;
    logic              mem_rnw;

    slot_decode decode_i (
        .active_slot  (active_slot),
        .slot_layout  (slot_layout),
        .ram_table    (ram_table),
        .sram_table   (sram_table),
        .active_block (active_block),
        .ram_entry    (ram_entry),
        .sram_entry   (sram_entry)
    );

    msx_mappers #(.ADDR_W(ADDR_W)) mappers_i (
        .clk          (clk),
        .rst          (rst),
        .addr         (addr),
        .cpu_din      (cpu_din),
        .rd           (rd),
        .wr           (wr),
        .active_block (active_block),
        .ram_blocks   (ram_entry.size),     // Sizes only, bases added later
        .sram_size    (sram_entry.size),
        .mem_offset   (mem_offset),
        .ram_cs       (ram_cs),
        .sram_cs      (sram_cs),
        .mem_rnw      (mem_rnw),
        .dev_cs       (dev_cs),
        .dev_num      (dev_num)
    );

    msx_slots #(.ADDR_W(ADDR_W)) slots_i (
        .cpu_din      (cpu_din),
        .ram_entry    (ram_entry),
        .sram_entry   (sram_entry),
        .mem_offset   (mem_offset),
        .ram_cs       (ram_cs),
        .sram_cs      (sram_cs),
        .mem_rnw      (mem_rnw),
        .dev_cs       (dev_cs),
        .ram_dout     (ram_dout),
        .dev_din      (dev_din),
        .ram_addr     (ram_addr),
        .ram_din      (ram_din),
        .ram_rnw      (ram_rnw),
        .sdram_ce     (sdram_ce),
        .data         (data)
    );

endmodule

// File: src/msx_slots.sv
`timescale 1ns/1ps

module msx_slots import msx_pkg::*; #(
    parameter int ADDR_W = 27
) (
    input  logic [7:0]        cpu_din,      // CPU write data
    input  lookup_ram_t       ram_entry,    // Active RAM/ROM region
    input  lookup_sram_t      sram_entry,   // Active SRAM region
    input  logic [ADDR_W-1:0] mem_offset,   // From the mapper
    input  logic              ram_cs,
    input  logic              sram_cs,
    input  logic              mem_rnw,
    input  logic              dev_cs,
    input  logic [7:0]        ram_dout,     // SDRAM read data
    input  logic [7:0]        dev_din,      // Device read data
    output logic [ADDR_W-1:0] ram_addr,
    output logic [7:0]        ram_din,
    output logic              ram_rnw,
    output logic              sdram_ce,
    output logic [7:0]        data          // Back to the CPU
);

    logic [ADDR_W-1:0] base_addr;
    logic              write_protect;

    // Region base
    always_comb begin
        if (sram_cs) begin
            base_addr = ADDR_W'(sram_entry.addr);
        end else begin
            base_addr = ADDR_W'(ram_entry.addr);
        end
    end

    assign ram_addr = base_addr + mem_offset;
    assign ram_din  = cpu_din;              // Write data straight from the CPU

    // One chip enable for both regions
    assign sdram_ce = ram_cs | sram_cs;

    // Protected RAM turns a write into a read
    assign write_protect = ram_cs & ram_entry.ro;
    assign ram_rnw       = mem_rnw | write_protect;

    // Read data return
    always_comb begin
        if (sdram_ce) begin
            data = ram_dout;
        end else if (dev_cs) begin
            data = dev_din;
        end else begin
            data = UNMAPPED_DATA;           // Nothing selected
        end
    end

endmodule

// File: src/slot_decode.sv
`timescale 1ns/1ps

module slot_decode import msx_pkg::*; (
    input  logic [1:0]           active_slot,   // Primary slot seen by the CPU
    input  block_t [3:0]         slot_layout,   // One layout word per slot
    input  lookup_ram_t [15:0]   ram_table,     // RAM/ROM regions
    input  lookup_sram_t [3:0]   sram_table,    // Battery backed regions
    output block_t               active_block,
    output lookup_ram_t          ram_entry,
    output lookup_sram_t         sram_entry
);

    block_t     sel_block;   // Layout word of the active slot
    block_mem_t mem_view;    // Payload read as a memory block
    logic       uses_tables; // Kind that needs lookup entries

    // Slot select
    assign sel_block = slot_layout[active_slot];

    // Memory view of the payload
    // Device blocks never come through here in a meaningful way
    assign mem_view = sel_block.payload.mem;

    // Only memory mapped kinds index the lookup tables
    always_comb begin
        case (sel_block.kind)
            MAP_ROM,
            MAP_RAM,
            MAP_ASCII8: uses_tables = 1'b1;
            default:    uses_tables = 1'b0;
        endcase
    end

    // RAM entry lookup
    always_comb begin
        if (uses_tables) begin
            ram_entry = ram_table[mem_view.ref_ram];
        end else begin
            ram_entry = '0;     // Keeps unused entry quiet
        end
    end

    // SRAM entry lookup
    always_comb begin
        if (uses_tables) begin
            sram_entry = sram_table[mem_view.ref_sram];
        end else begin
            sram_entry = '0;
        end
    end

    // Block word goes on unchanged to the mappers
    assign active_block = sel_block;

endmodule
